// File: include/aabb_defines.svh
`ifndef AABB_DEFINES_SVH
`define AABB_DEFINES_SVH

// coordinates and reciprocals are two's complement fixed point
`define AABB_COORD_W 16
`define AABB_FRAC_W 8 // fraction bits of a coordinate

// x, y and z
`define AABB_AXES 3

// difference times reciprocal keeps every bit with one spare on top
`define AABB_T_W 34

`endif

// File: hw/aabb_pkg.sv
`include "aabb_defines.svh"

package aabb_pkg;

	//////////////////////////////////////////////////
	// scalar types
	//////////////////////////////////////////////////

	typedef logic signed [`AABB_COORD_W-1:0] coord_t; // origin, corner or 1/dir
	typedef logic signed [`AABB_COORD_W:0] diff_t; // corner minus origin
	typedef logic signed [`AABB_T_W-1:0] tval_t; // distance along the ray

	// distances carry the fraction bits of both factors
	localparam int T_FRAC_W = 2 * `AABB_FRAC_W;

	//////////////////////////////////////////////////
	// per-axis vectors, index 0 is x
	//////////////////////////////////////////////////

	typedef coord_t [`AABB_AXES-1:0] coord_vec_t;
	typedef diff_t [`AABB_AXES-1:0] diff_vec_t;
	typedef tval_t [`AABB_AXES-1:0] tval_vec_t;
	typedef logic [`AABB_AXES-1:0] axis_mask_t;

	// unbounded interval for an axis the ray runs parallel to
	localparam tval_t T_NEG_INF = {1'b1, {(`AABB_T_W-1){1'b0}}};
	localparam tval_t T_POS_INF = {1'b0, {(`AABB_T_W-1){1'b1}}};

endpackage

// File: hw/slab_links.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////
// stage 1 to stage 2
//////////////////////////////////////////////////

interface diff_link;
	logic valid;
	logic ready;
	aabb_pkg::diff_vec_t d_lo; // box_min - origin
	aabb_pkg::diff_vec_t d_hi; // box_max - origin
	aabb_pkg::coord_vec_t inv; // reciprocal direction
	aabb_pkg::axis_mask_t par; // parallel flags
	logic reject; // origin outside a parallel slab

	modport src (
		output valid,
		output d_lo,
		output d_hi,
		output inv,
		output par,
		output reject,
		input ready
	);

	modport snk (
		input valid,
		input d_lo,
		input d_hi,
		input inv,
		input par,
		input reject,
		output ready
	);
endinterface

//////////////////////////////////////////////////
// stage 2 to stage 3
//////////////////////////////////////////////////

interface span_link;
	logic valid;
	logic ready;
	aabb_pkg::tval_vec_t t_lo; // entry per axis
	aabb_pkg::tval_vec_t t_hi; // exit per axis
	logic reject;

	modport src (output valid, output t_lo, output t_hi, output reject, input ready);
	modport snk (input valid, input t_lo, input t_hi, input reject, output ready);
endinterface

//////////////////////////////////////////////////
// stage 3 to stage 4
//////////////////////////////////////////////////

interface bound_link;
	logic valid;
	logic ready;
	aabb_pkg::tval_t t_near;
	aabb_pkg::tval_t t_far;
	logic reject;

	modport src (output valid, output t_near, output t_far, output reject, input ready);
	modport snk (input valid, input t_near, input t_far, input reject, output ready);
endinterface

// File: hw/slab_diff.sv
`timescale 1ns/1ps
`include "aabb_defines.svh"

module slab_diff (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input aabb_pkg::coord_vec_t origin,
	input aabb_pkg::coord_vec_t box_min,
	input aabb_pkg::coord_vec_t box_max,
	input aabb_pkg::coord_vec_t inv_dir,
	input aabb_pkg::axis_mask_t parallel,
	diff_link.src down
);

	logic valid_q;
	logic take;
	aabb_pkg::diff_vec_t d_lo_n;
	aabb_pkg::diff_vec_t d_hi_n;
	aabb_pkg::axis_mask_t outside; // origin not between the slab planes

	assign in_ready = ~valid_q | down.ready; // empty or draining
	assign take = in_valid & in_ready;
	assign down.valid = valid_q;

	always_comb begin
		for (int a = 0; a < `AABB_AXES; a++) begin
			d_lo_n[a] = aabb_pkg::diff_t'($signed(box_min[a]))
				- aabb_pkg::diff_t'($signed(origin[a]));
			d_hi_n[a] = aabb_pkg::diff_t'($signed(box_max[a]))
				- aabb_pkg::diff_t'($signed(origin[a]));
			outside[a] = ($signed(origin[a]) < $signed(box_min[a]))
				|| ($signed(origin[a]) > $signed(box_max[a]));
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (take) begin
			valid_q <= 1'b1;
		end else if (down.ready) begin
			valid_q <= 1'b0;
		end
	end

	// payload only moves on a transfer
	always_ff @(posedge clk) begin
		if (take) begin
			down.d_lo <= d_lo_n;
			down.d_hi <= d_hi_n;
			down.inv <= inv_dir;
			down.par <= parallel;
			down.reject <= |(parallel & outside); // parallel and outside is a miss
		end
	end

endmodule

// File: hw/slab_scale.sv
`timescale 1ns/1ps
`include "aabb_defines.svh"

module slab_scale (
	input logic clk,
	input logic rst,
	diff_link.snk up,
	span_link.src down
);

	logic valid_q;
	logic take;
	aabb_pkg::tval_vec_t p_lo; // d_lo scaled by 1/dir
	aabb_pkg::tval_vec_t p_hi; // d_hi scaled by 1/dir
	aabb_pkg::tval_vec_t lo_n;
	aabb_pkg::tval_vec_t hi_n;

	assign up.ready = ~valid_q | down.ready;
	assign take = up.valid & up.ready;
	assign down.valid = valid_q;

	//////////////////////////////////////////////////
	// per-axis entry and exit distances
	//////////////////////////////////////////////////

	always_comb begin
		for (int a = 0; a < `AABB_AXES; a++) begin
			p_lo[a] = aabb_pkg::tval_t'($signed(up.d_lo[a]))
				* aabb_pkg::tval_t'($signed(up.inv[a]));
			p_hi[a] = aabb_pkg::tval_t'($signed(up.d_hi[a]))
				* aabb_pkg::tval_t'($signed(up.inv[a]));

			if (up.par[a]) begin
				// no bound from this axis
				lo_n[a] = aabb_pkg::T_NEG_INF;
				hi_n[a] = aabb_pkg::T_POS_INF;
			end else if (up.inv[a][`AABB_COORD_W-1]) begin
				// ray heads toward -axis so max plane is hit first
				lo_n[a] = p_hi[a];
				hi_n[a] = p_lo[a];
			end else begin
				lo_n[a] = p_lo[a];
				hi_n[a] = p_hi[a];
			end
		end
	end

	//////////////////////////////////////////////////
	// stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (take) begin
			valid_q <= 1'b1;
		end else if (down.ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			down.t_lo <= lo_n;
			down.t_hi <= hi_n;
			down.reject <= up.reject;
		end
	end

endmodule

// File: hw/slab_merge.sv
`timescale 1ns/1ps
`include "aabb_defines.svh"

module slab_merge (
	input logic clk,
	input logic rst,
	span_link.snk up,
	bound_link.src down
);

	logic valid_q;
	logic take;
	aabb_pkg::tval_t near_n; // latest entry over all axes
	aabb_pkg::tval_t far_n; // earliest exit over all axes

	assign up.ready = ~valid_q | down.ready;
	assign take = up.valid & up.ready;
	assign down.valid = valid_q;

	// intersect the axis intervals
	always_comb begin
		near_n = $signed(up.t_lo[0]);
		far_n = $signed(up.t_hi[0]);
		for (int a = 1; a < `AABB_AXES; a++) begin
			if ($signed(up.t_lo[a]) > near_n) begin
				near_n = $signed(up.t_lo[a]);
			end
			if ($signed(up.t_hi[a]) < far_n) begin
				far_n = $signed(up.t_hi[a]);
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (take) begin
			valid_q <= 1'b1;
		end else if (down.ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			down.t_near <= near_n;
			down.t_far <= far_n;
			down.reject <= up.reject; // carried to the decision
		end
	end

endmodule

// File: hw/hit_decide.sv
`timescale 1ns/1ps

module hit_decide (
	input logic clk,
	input logic rst,
	bound_link.snk up,
	output logic out_valid,
	input logic out_ready,
	output logic hit,
	output aabb_pkg::tval_t t_near,
	output aabb_pkg::tval_t t_far
);

	logic take;
	logic far_ge_near; // intervals overlap
	logic far_ahead; // exit lies in front of the origin

	assign up.ready = ~out_valid | out_ready;
	assign take = up.valid & up.ready;

	assign far_ge_near = up.t_far >= up.t_near;
	assign far_ahead = up.t_far > 0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (take) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0; // result consumed
		end
	end

	// result register
	always_ff @(posedge clk) begin
		if (take) begin
			hit <= ~up.reject & far_ge_near & far_ahead;
			t_near <= up.t_near;
			t_far <= up.t_far;
		end
	end

endmodule

// File: hw/ray_aabb_top.sv
`timescale 1ns/1ps

module ray_aabb_top (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input aabb_pkg::coord_t origin_x,
	input aabb_pkg::coord_t origin_y,
	input aabb_pkg::coord_t origin_z,
	input aabb_pkg::coord_t min_x,
	input aabb_pkg::coord_t min_y,
	input aabb_pkg::coord_t min_z,
	input aabb_pkg::coord_t max_x,
	input aabb_pkg::coord_t max_y,
	input aabb_pkg::coord_t max_z,
	input aabb_pkg::coord_t inv_x,
	input aabb_pkg::coord_t inv_y,
	input aabb_pkg::coord_t inv_z,
	input aabb_pkg::axis_mask_t parallel, // bit 0 is x
	output logic out_valid,
	input logic out_ready,
	output logic hit,
	output aabb_pkg::tval_t t_near,
	output aabb_pkg::tval_t t_far
);

	aabb_pkg::coord_vec_t origin;
	aabb_pkg::coord_vec_t box_min;
	aabb_pkg::coord_vec_t box_max;
	aabb_pkg::coord_vec_t inv_dir;

	// x in the low slot
	assign origin = {origin_z, origin_y, origin_x};
	assign box_min = {min_z, min_y, min_x};
	assign box_max = {max_z, max_y, max_x};
	assign inv_dir = {inv_z, inv_y, inv_x};

	//////////////////////////////////////////////////
	// stage links
	//////////////////////////////////////////////////

	diff_link diff_l ();
	span_link span_l ();
	bound_link bound_l ();

	//////////////////////////////////////////////////
	// four stage pipeline
	//////////////////////////////////////////////////

	slab_diff diff0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.origin(origin),
		.box_min(box_min),
		.box_max(box_max),
		.inv_dir(inv_dir),
		.parallel(parallel),
		.down(diff_l.src)
	);

	slab_scale scale0 (
		.clk(clk),
		.rst(rst),
		.up(diff_l.snk),
		.down(span_l.src)
	);

	slab_merge merge0 (
		.clk(clk),
		.rst(rst),
		.up(span_l.snk),
		.down(bound_l.src)
	);

	hit_decide decide0 (
		.clk(clk),
		.rst(rst),
		.up(bound_l.snk),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.hit(hit),
		.t_near(t_near),
		.t_far(t_far)
	);

endmodule

// File: tb/tb_ray_aabb.sv
`timescale 1ns/1ps
`include "aabb_defines.svh"

module tb_ray_aabb;

	localparam int NUM_DIRECTED = 13;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_ROWS = NUM_DIRECTED + NUM_RANDOM;
	localparam int CW = `AABB_COORD_W;
	localparam longint T_MAX = (longint'(1) <<< (`AABB_T_W - 1)) - 1;
	localparam longint T_MIN = -T_MAX - 1;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	logic signed [CW-1:0] org_drv [3]; // index 0 is x
	logic signed [CW-1:0] min_drv [3];
	logic signed [CW-1:0] max_drv [3];
	logic signed [CW-1:0] inv_drv [3];
	logic [`AABB_AXES-1:0] parallel;
	logic out_valid;
	logic out_ready;
	logic hit;
	logic signed [`AABB_T_W-1:0] t_near;
	logic signed [`AABB_T_W-1:0] t_far;

	// stimulus table with 8 fraction bits per coordinate and 16 per distance
	int row_org [NUM_ROWS][3];
	int row_min [NUM_ROWS][3];
	int row_max [NUM_ROWS][3];
	int row_inv [NUM_ROWS][3];
	logic [`AABB_AXES-1:0] row_par [NUM_ROWS];
	logic row_hit [NUM_ROWS];
	longint row_near [NUM_ROWS];
	longint row_far [NUM_ROWS];
	int row_count = 0;

	int row_q [$]; // rows in flight with the oldest first
	int acc_q [$]; // acceptance cycle of each row in flight
	int cur_row = 0;
	int sent = 0;
	int received = 0;
	int cycle = 0;
	logic lat_check = 1'b0; // latency is fixed while nothing stalls
	logic stall_on = 1'b0;
	logic [31:0] stim_state = 32'h1126;

	ray_aabb_top dut0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.origin_x(org_drv[0]),
		.origin_y(org_drv[1]),
		.origin_z(org_drv[2]),
		.min_x(min_drv[0]),
		.min_y(min_drv[1]),
		.min_z(min_drv[2]),
		.max_x(max_drv[0]),
		.max_y(max_drv[1]),
		.max_z(max_drv[2]),
		.inv_x(inv_drv[0]),
		.inv_y(inv_drv[1]),
		.inv_z(inv_drv[2]),
		.parallel(parallel),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.hit(hit),
		.t_near(t_near),
		.t_far(t_far)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// uniform in [-2^(bits-1), 2^(bits-1))
	function automatic int draw_signed(input int bits);
		int span;
		span = 1 << bits;
		stim_state = lcg_step(stim_state);
		return int'(stim_state[31:16]) % span - span / 2;
	endfunction

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "run stopped on error");
	endtask

	task automatic add_row(input int ox, input int oy, input int oz,
		input int lx, input int ly, input int lz, input int hx, input int hy, input int hz,
		input int ix, input int iy, input int iz, input logic [2:0] par,
		input logic h, input longint tn, input longint tf);
		row_org[row_count] = '{ox, oy, oz};
		row_min[row_count] = '{lx, ly, lz};
		row_max[row_count] = '{hx, hy, hz};
		row_inv[row_count] = '{ix, iy, iz};
		row_par[row_count] = par;
		row_hit[row_count] = h;
		row_near[row_count] = tn;
		row_far[row_count] = tf;
		row_count++;
	endtask

	// slab rule on exact integers
	function automatic void predict(input int r);
		longint lo;
		longint hi;
		longint p1;
		longint p2;
		longint near;
		longint far;
		logic rej;
		near = T_MIN;
		far = T_MAX;
		rej = 1'b0;
		for (int a = 0; a < 3; a++) begin
			if (row_par[r][a]) begin
				if (row_org[r][a] < row_min[r][a] || row_org[r][a] > row_max[r][a])
					rej = 1'b1; // parallel and outside the slab
				lo = T_MIN;
				hi = T_MAX;
			end else begin
				p1 = longint'(row_min[r][a] - row_org[r][a]) * longint'(row_inv[r][a]);
				p2 = longint'(row_max[r][a] - row_org[r][a]) * longint'(row_inv[r][a]);
				lo = (row_inv[r][a] < 0) ? p2 : p1; // negative direction swaps
				hi = (row_inv[r][a] < 0) ? p1 : p2;
			end
			if (lo > near)
				near = lo;
			if (hi < far)
				far = hi;
		end
		row_near[r] = near;
		row_far[r] = far;
		row_hit[r] = !rej && (far >= near) && (far > 0);
	endfunction

	task automatic build_directed();
		// crossing ray with all reciprocals positive
		add_row(0, 0, 0, 256, 512, -256, 1280, 1024, 768,
			256, 128, 512, 3'b000, 1'b1, 65536, 131072);
		// box behind the origin
		add_row(2560, 2560, 2560, 256, 256, 256, 768, 768, 768,
			256, 256, 256, 3'b000, 1'b0, -589824, -458752);
		// slabs do not overlap
		add_row(0, 0, 0, 256, 1280, 0, 512, 1536, 256,
			256, 256, 256, 3'b000, 1'b0, 327680, 65536);
		// negative x reciprocal
		add_row(2048, 0, 0, 512, -4096, -4096, 1024, 4096, 4096,
			-256, 256, 256, 3'b000, 1'b1, 262144, 393216);
		// negative x and y
		add_row(0, 0, 0, -1536, -2048, 256, -512, -256, 768,
			-256, -128, 256, 3'b000, 1'b1, 131072, 196608);
		// x parallel with the origin inside
		add_row(256, 0, 0, 0, 512, 512, 768, 1024, 1024,
			0, 256, 256, 3'b001, 1'b1, 131072, 262144);
		// x parallel with the origin outside
		add_row(1280, 0, 0, 0, 512, 512, 768, 1024, 1024,
			0, 256, 256, 3'b001, 1'b0, 131072, 262144);
		// y parallel with the origin below the slab
		add_row(0, -768, 0, 256, -512, 256, 512, 512, 512,
			256, 0, 256, 3'b010, 1'b0, 65536, 131072);
		// all parallel with the origin inside
		add_row(256, 256, 256, 0, 0, 0, 512, 512, 512,
			0, 0, 0, 3'b111, 1'b1, T_MIN, T_MAX);
		// all parallel with z outside
		add_row(256, 256, 1280, 0, 0, 0, 512, 512, 512,
			0, 0, 0, 3'b111, 1'b0, T_MIN, T_MAX);
		// origin inside the box
		add_row(256, 256, 256, 0, 0, 0, 1024, 1024, 1024,
			256, 256, 256, 3'b000, 1'b1, -65536, 196608);
		// t_far equals t_near
		add_row(0, 0, 0, 256, 512, 0, 512, 768, 1280,
			256, 256, 256, 3'b000, 1'b1, 131072, 131072);
		// exit exactly at the origin
		add_row(512, 512, 512, 0, 0, 0, 512, 512, 512,
			256, 256, 256, 3'b000, 1'b0, -131072, 0);
	endtask

	task automatic build_random();
		int v1;
		int v2;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			for (int a = 0; a < 3; a++) begin
				v1 = draw_signed(12);
				v2 = draw_signed(12);
				row_org[row_count][a] = draw_signed(12);
				row_min[row_count][a] = (v1 < v2) ? v1 : v2;
				row_max[row_count][a] = (v1 < v2) ? v2 : v1;
				row_inv[row_count][a] = draw_signed(11);
				row_par[row_count][a] = (draw_signed(3) == -4); // about one in eight
			end
			predict(row_count);
			row_count++;
		end
	endtask

	// drive one row and hold it until the DUT takes it
	task automatic send_row(input int r);
		int target;
		target = sent + 1;
		for (int a = 0; a < 3; a++) begin
			org_drv[a] = CW'(row_org[r][a]);
			min_drv[a] = CW'(row_min[r][a]);
			max_drv[a] = CW'(row_max[r][a]);
			inv_drv[a] = CW'(row_inv[r][a]);
		end
		parallel = row_par[r];
		cur_row = r;
		in_valid = 1'b1;
		do @(negedge clk); while (sent != target);
	endtask

	task automatic wait_drain();
		while (received != sent)
			@(negedge clk);
	endtask

	//////////////////////////////////////////////////
	// scoreboard sampled on the rising edge
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		int r;
		int acc;
		if (!rst) begin
			if (in_valid && in_ready) begin
				row_q.push_back(cur_row);
				acc_q.push_back(cycle);
				sent++;
			end
			if (out_valid && out_ready) begin
				if (row_q.size() == 0) begin
					$display("result handed out with no item in flight, cycle %0d", cycle);
					abort_run();
				end else begin
					r = row_q.pop_front();
					acc = acc_q.pop_front();
					assert (hit === row_hit[r]) else begin
						$display("CHECK FAILED hit row %0d expected %h got %h", r, row_hit[r], hit);
						abort_run();
					end
					assert (longint'(t_near) == row_near[r]) else begin
						$display("CHECK FAILED t_near row %0d expected %h got %h",
							r, row_near[r], longint'(t_near));
						abort_run();
					end
					assert (longint'(t_far) == row_far[r]) else begin
						$display("CHECK FAILED t_far row %0d expected %h got %h",
							r, row_far[r], longint'(t_far));
						abort_run();
					end
					assert (!lat_check || cycle - acc == 4) else begin
						$display("CHECK FAILED latency row %0d expected %h got %h",
							r, 4, cycle - acc);
						abort_run();
					end
					received++;
				end
			end
		end
		cycle++;
	end

	// random back-pressure from its own generator state
	initial begin
		logic [31:0] bp_state;
		bp_state = 32'h1126;
		out_ready = 1'b1;
		forever begin
			@(negedge clk);
			if (stall_on) begin
				bp_state = lcg_step(bp_state);
				out_ready = (bp_state[31:16] % 3) != 0; // low about a third of the time
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	initial begin
		repeat (16 + (NUM_ROWS + 8) * 4) @(posedge clk);
		$display("timeout: the pipeline stopped returning results in time");
		abort_run();
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		parallel = '0;
		for (int a = 0; a < 3; a++) begin
			org_drv[a] = '0;
			min_drv[a] = '0;
			max_drv[a] = '0;
			inv_drv[a] = '0;
		end
		build_directed();
		build_random();

		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		assert (out_valid === 1'b0) else begin
			$display("CHECK FAILED out_valid after reset expected %h got %h", 1'b0, out_valid);
			abort_run();
		end
		assert (in_ready === 1'b1) else begin
			$display("CHECK FAILED in_ready after reset expected %h got %h", 1'b1, in_ready);
			abort_run();
		end

		lat_check = 1'b1; // directed rows back to back without stalls
		for (int r = 0; r < NUM_DIRECTED; r++)
			send_row(r);
		in_valid = 1'b0;
		wait_drain();
		lat_check = 1'b0;

		stall_on = 1'b1;
		for (int r = NUM_DIRECTED; r < NUM_ROWS; r++)
			send_row(r);
		in_valid = 1'b0;
		wait_drain();
		repeat (8) @(negedge clk); // any stray result would show up here

		$display("%0d results checked", received);
		$display("test passed");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
hw/aabb_pkg.sv
hw/slab_links.sv
hw/slab_diff.sv
hw/slab_scale.sv
hw/slab_merge.sv
hw/hit_decide.sv
hw/ray_aabb_top.sv
tb/tb_ray_aabb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the ray/box testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=sim_ray_aabb

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ray_aabb -f project.f -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$SIM_BIN" > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "test failed" "$SIM_LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi
exit 0
